//--- src/ctrlPkg.sv
package ctrlPkg;

	////////////////////////////////////////
	// instruction fields
	////////////////////////////////////////

	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opJal   = 6'h03;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti  = 6'h0a;
	localparam logic [5:0] opSltiu = 6'h0b;
	localparam logic [5:0] opAndi  = 6'h0c;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// function field for opcode zero
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnJalr = 6'h09;

	////////////////////////////////////////
	// states and classes
	////////////////////////////////////////

	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stExecute,
		stMemRead,
		stLoadWrite,
		stMemWrite,
		stRegWrite,
		stRegJump,
		stOverflowErr
	} ctrlState;

	typedef enum logic [3:0] {
		clsRAlu,
		clsRShift,
		clsRJump,   // jr
		clsRLink,   // jalr
		clsImmAlu,
		clsLoad,
		clsStore,
		clsBranch,
		clsJump,
		clsJumpLink,
		clsUnsupported
	} instrClass;

	////////////////////////////////////////
	// datapath selects
	////////////////////////////////////////

	typedef enum logic [1:0] {srcAPc = 2'b00, srcAReg = 2'b01, srcAShamt = 2'b10} aluSrcASel;
	typedef enum logic [1:0] {
		srcBReg    = 2'b00,
		srcBFour   = 2'b01,
		srcBImm    = 2'b10,
		srcBBranch = 2'b11    // shifted sign-extended offset
	} aluSrcBSel;
	typedef enum logic [1:0] {
		pcAluResult  = 2'b00,
		pcAluOutReg  = 2'b01,
		pcJumpTarget = 2'b11
	} pcSourceSel;
	typedef enum logic [1:0] {dstRt = 2'b00, dstRd = 2'b01, dstRa = 2'b10} regDstSel;

	localparam int aluCodeWidth = 4;
	localparam int aluOpWidth = 3;  // operation part below the unsigned bit

	localparam logic [aluOpWidth-1:0] aluOpAdd   = 3'b000;
	localparam logic [aluOpWidth-1:0] aluOpSub   = 3'b001;
	localparam logic [aluOpWidth-1:0] aluOpRType = 3'b010;  // ALU decodes funct
	localparam logic [aluOpWidth-1:0] aluOpAddu  = 3'b011;
	localparam logic [aluOpWidth-1:0] aluOpAnd   = 3'b100;
	localparam logic [aluOpWidth-1:0] aluOpSlt   = 3'b101;

	// every datapath control in 25 bits
	typedef struct packed {
		logic pcWrite;
		logic pcWriteCond;
		logic iOrD;
		logic memWrite;
		logic memRead;
		logic irWrite;
		logic memToReg;
		logic regWrite;
		logic extOp;
		logic luiOp;
		logic pcOrData;
		logic err;
		logic erWrite;
		regDstSel regDst;
		aluSrcASel aluSrcA;
		aluSrcBSel aluSrcB;
		pcSourceSel pcSource;
		logic [aluCodeWidth-1:0] aluOp;
	} ctrlWord;

endpackage

//--- src/decodeIf.sv
interface decodeIf;

	ctrlPkg::instrClass cls;
	logic [ctrlPkg::aluCodeWidth-1:0] aluCode;  // ALU code for execute
	logic extOp;    // sign-extend immediate
	logic luiOp;
	logic shift;    // sll, srl, sra

	modport producer (
		output cls,
		output aluCode,
		output extOp,
		output luiOp,
		output shift
	);

	modport consumer (
		input cls,
		input aluCode,
		input extOp,
		input luiOp,
		input shift
	);

endinterface

//--- src/instrDecoder.sv
module instrDecoder (
	input logic [5:0] opCode,
	input logic [5:0] funct,
	decodeIf.producer dec
);

	logic [ctrlPkg::aluOpWidth-1:0] opPart;

	////////////////////////////////////////
	// instruction class
	////////////////////////////////////////

	always_comb
	begin
		dec.cls = ctrlPkg::clsUnsupported;
		dec.shift = 1'b0;
		case (opCode)
			ctrlPkg::opRType:
			begin
				case (funct)
					ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra:
					begin
						dec.cls = ctrlPkg::clsRShift;
						dec.shift = 1'b1;
					end
					ctrlPkg::fnJr:
						dec.cls = ctrlPkg::clsRJump;
					ctrlPkg::fnJalr:
						dec.cls = ctrlPkg::clsRLink;
					default:
						dec.cls = ctrlPkg::clsRAlu;   // ALU resolves funct
				endcase
			end
			ctrlPkg::opLui,
			ctrlPkg::opAddi,
			ctrlPkg::opAddiu,
			ctrlPkg::opAndi,
			ctrlPkg::opOri,
			ctrlPkg::opSlti,
			ctrlPkg::opSltiu:
				dec.cls = ctrlPkg::clsImmAlu;
			ctrlPkg::opLw:
				dec.cls = ctrlPkg::clsLoad;
			ctrlPkg::opSw:
				dec.cls = ctrlPkg::clsStore;
			ctrlPkg::opBeq:
				dec.cls = ctrlPkg::clsBranch;
			ctrlPkg::opJ:
				dec.cls = ctrlPkg::clsJump;
			ctrlPkg::opJal:
				dec.cls = ctrlPkg::clsJumpLink;
			default:
				dec.cls = ctrlPkg::clsUnsupported;
		endcase
	end

	////////////////////////////////////////
	// ALU code and immediate handling
	////////////////////////////////////////

	always_comb
	begin
		case (opCode)
			ctrlPkg::opRType:
				opPart = ctrlPkg::aluOpRType;
			ctrlPkg::opBeq:
				opPart = ctrlPkg::aluOpSub;   // compare by subtract
			ctrlPkg::opAndi:
				opPart = ctrlPkg::aluOpAnd;
			ctrlPkg::opSlti, ctrlPkg::opSltiu:
				opPart = ctrlPkg::aluOpSlt;
			ctrlPkg::opAddiu:
				opPart = ctrlPkg::aluOpAddu;
			default:
				opPart = ctrlPkg::aluOpAdd;
		endcase
	end

	// low opcode bit doubles as the unsigned flag
	assign dec.aluCode = {opCode[0], opPart};

	assign dec.extOp = (opCode != ctrlPkg::opAndi);   // andi zero-extends
	assign dec.luiOp = (opCode == ctrlPkg::opLui);

endmodule

//--- src/stateSequencer.sv
module stateSequencer (
	input logic clk,
	input logic reset,
	input logic overflow,
	decodeIf.consumer dec,
	output ctrlPkg::ctrlState state
);

	ctrlPkg::ctrlState nextState;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= ctrlPkg::stFetch;
		else
			state <= nextState;
	end

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		nextState = ctrlPkg::stFetch;
		case (state)
			ctrlPkg::stFetch:
				nextState = ctrlPkg::stDecode;
			ctrlPkg::stDecode:
				nextState = ctrlPkg::stExecute;
			ctrlPkg::stExecute:
			begin
				case (dec.cls)
					ctrlPkg::clsRAlu,
					ctrlPkg::clsRShift,
					ctrlPkg::clsImmAlu:
						nextState = ctrlPkg::stRegWrite;
					ctrlPkg::clsLoad:
						nextState = ctrlPkg::stMemRead;
					ctrlPkg::clsStore:
						nextState = ctrlPkg::stMemWrite;
					ctrlPkg::clsRJump,
					ctrlPkg::clsRLink:
						nextState = ctrlPkg::stRegJump;
					default:
						nextState = ctrlPkg::stFetch;   // branch, j, jal, unsupported
				endcase
			end
			ctrlPkg::stMemRead:
				nextState = ctrlPkg::stLoadWrite;
			ctrlPkg::stRegWrite:
			begin
				// overflow only matters here
				if (overflow)
					nextState = ctrlPkg::stOverflowErr;
				else
					nextState = ctrlPkg::stFetch;
			end
			default:
				nextState = ctrlPkg::stFetch;   // last state of an instruction
		endcase
	end

endmodule

//--- src/controlWordGen.sv
module controlWordGen (
	input logic reset,
	input ctrlPkg::ctrlState state,
	decodeIf.consumer dec,
	output ctrlPkg::ctrlWord ctrl
);

	always_comb
	begin
		ctrl = '0;
		if (!reset)
		begin
			// immediate controls follow the opcode in every state
			ctrl.extOp = dec.extOp;
			ctrl.luiOp = dec.luiOp;
			case (state)
				ctrlPkg::stFetch:
				begin
					ctrl.memRead = 1'b1;
					ctrl.irWrite = 1'b1;
					ctrl.pcWrite = 1'b1;   // pc + 4
					ctrl.aluSrcB = ctrlPkg::srcBFour;
				end
				ctrlPkg::stDecode:
					ctrl.aluSrcB = ctrlPkg::srcBBranch;   // branch target into ALU out
				ctrlPkg::stExecute:
				begin
					ctrl.aluOp = dec.aluCode;
					case (dec.cls)
						ctrlPkg::clsImmAlu,
						ctrlPkg::clsLoad,
						ctrlPkg::clsStore:
						begin
							ctrl.aluSrcA = ctrlPkg::srcAReg;
							ctrl.aluSrcB = ctrlPkg::srcBImm;
						end
						ctrlPkg::clsBranch:
						begin
							ctrl.aluSrcA = ctrlPkg::srcAReg;
							ctrl.pcWriteCond = 1'b1;
							ctrl.pcSource = ctrlPkg::pcAluOutReg;
						end
						ctrlPkg::clsJump:
						begin
							ctrl.pcWrite = 1'b1;
							ctrl.pcSource = ctrlPkg::pcJumpTarget;
						end
						ctrlPkg::clsJumpLink:
						begin
							ctrl.pcWrite = 1'b1;
							ctrl.pcSource = ctrlPkg::pcJumpTarget;
							ctrl.regWrite = 1'b1;
							ctrl.regDst = ctrlPkg::dstRa;
							ctrl.pcOrData = 1'b1;   // link address
						end
						ctrlPkg::clsRAlu,
						ctrlPkg::clsRShift,
						ctrlPkg::clsRJump,
						ctrlPkg::clsRLink:
						begin
							if (dec.shift)
								ctrl.aluSrcA = ctrlPkg::srcAShamt;
							else
								ctrl.aluSrcA = ctrlPkg::srcAReg;
						end
						default:
							ctrl.aluSrcA = ctrlPkg::srcAPc;   // unsupported writes nothing
					endcase
				end
				ctrlPkg::stMemRead:
				begin
					ctrl.memRead = 1'b1;
					ctrl.iOrD = 1'b1;
				end
				ctrlPkg::stLoadWrite:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.memToReg = 1'b1;
					ctrl.regDst = ctrlPkg::dstRt;
				end
				ctrlPkg::stMemWrite:
				begin
					ctrl.memWrite = 1'b1;
					ctrl.iOrD = 1'b1;
				end
				ctrlPkg::stRegWrite:
				begin
					ctrl.regWrite = 1'b1;
					if (dec.cls == ctrlPkg::clsImmAlu)
						ctrl.regDst = ctrlPkg::dstRt;
					else
						ctrl.regDst = ctrlPkg::dstRd;
				end
				ctrlPkg::stRegJump:
				begin
					ctrl.pcWrite = 1'b1;
					ctrl.pcSource = ctrlPkg::pcAluOutReg;   // rs
					if (dec.cls == ctrlPkg::clsRLink)
					begin
						ctrl.regWrite = 1'b1;
						ctrl.regDst = ctrlPkg::dstRd;
						ctrl.pcOrData = 1'b1;
					end
				end
				ctrlPkg::stOverflowErr:
				begin
					ctrl.err = 1'b1;
					ctrl.erWrite = 1'b1;
					ctrl.pcWrite = 1'b1;   // to handler
				end
				default:
					ctrl.pcWrite = 1'b0;
			endcase
		end
	end

endmodule

//--- src/mcController.sv
module mcController (
	input logic clk,
	input logic reset,
	input logic [5:0] opCode,
	input logic [5:0] funct,
	input logic overflow,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic iOrD,
	output logic memWrite,
	output logic memRead,
	output logic irWrite,
	output logic memToReg,
	output logic [1:0] regDst,
	output logic regWrite,
	output logic extOp,
	output logic luiOp,
	output logic [1:0] aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [3:0] aluOp,
	output logic [1:0] pcSource,
	output logic pcOrData,
	output logic err,
	output logic erWrite
);

	ctrlPkg::ctrlState state;
	ctrlPkg::ctrlWord ctrl;

	decodeIf decBus ();

	instrDecoder uDecoder (
		.opCode (opCode),
		.funct  (funct),
		.dec    (decBus.producer)
	);

	stateSequencer uSequencer (
		.clk      (clk),
		.reset    (reset),
		.overflow (overflow),
		.dec      (decBus.consumer),
		.state    (state)
	);

	controlWordGen uWordGen (
		.reset (reset),
		.state (state),
		.dec   (decBus.consumer),
		.ctrl  (ctrl)
	);

	////////////////////////////////////////
	// control word onto datapath pins
	////////////////////////////////////////

	assign pcWrite     = ctrl.pcWrite;
	assign pcWriteCond = ctrl.pcWriteCond;
	assign iOrD        = ctrl.iOrD;
	assign memWrite    = ctrl.memWrite;
	assign memRead     = ctrl.memRead;
	assign irWrite     = ctrl.irWrite;
	assign memToReg    = ctrl.memToReg;
	assign regDst      = ctrl.regDst;
	assign regWrite    = ctrl.regWrite;
	assign extOp       = ctrl.extOp;
	assign luiOp       = ctrl.luiOp;
	assign aluSrcA     = ctrl.aluSrcA;
	assign aluSrcB     = ctrl.aluSrcB;
	assign aluOp       = ctrl.aluOp;
	assign pcSource    = ctrl.pcSource;
	assign pcOrData    = ctrl.pcOrData;
	assign err         = ctrl.err;
	assign erWrite     = ctrl.erWrite;

endmodule

//--- dv/controllerTb.sv
module controllerTb;

	localparam int nEntry = 19;
	localparam int sF = 0, sD = 1, sE = 2, sMR = 3, sLW = 4, sMW = 5, sRW = 6, sRJ = 7,
		sOE = 8;
	localparam int kR = 0, kShift = 1, kJr = 2, kJalr = 3, kImm = 4, kLw = 5, kSw = 6,
		kBeq = 7, kJ = 8, kJal = 9, kBad = 10;

	////////////////////////////////////////
	// instruction table
	////////////////////////////////////////

	localparam logic [5:0] tblOp [nEntry] = '{
		ctrlPkg::opRType, ctrlPkg::opRType, ctrlPkg::opRType, ctrlPkg::opRType,
		ctrlPkg::opRType, ctrlPkg::opRType, ctrlPkg::opLui, ctrlPkg::opAddi,
		ctrlPkg::opAddiu, ctrlPkg::opAndi, ctrlPkg::opOri, ctrlPkg::opSlti,
		ctrlPkg::opSltiu, ctrlPkg::opLw, ctrlPkg::opSw, ctrlPkg::opBeq,
		ctrlPkg::opJ, ctrlPkg::opJal, 6'h3f   // last one is not decoded
	};
	localparam logic [5:0] tblFn [nEntry] = '{
		6'h20, ctrlPkg::fnSll, ctrlPkg::fnSrl, ctrlPkg::fnSra, ctrlPkg::fnJr, ctrlPkg::fnJalr,
		6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00
	};
	localparam int tblKind [nEntry] = '{
		kR, kShift, kShift, kShift, kJr, kJalr, kImm, kImm, kImm, kImm, kImm, kImm, kImm,
		kLw, kSw, kBeq, kJ, kJal, kBad
	};
	string tblName [nEntry] = '{"add", "sll", "srl", "sra", "jr", "jalr", "lui", "addi",
		"addiu", "andi", "ori", "slti", "sltiu", "lw", "sw", "beq", "j", "jal", "undefined"};

	logic clk;
	logic reset;
	logic overflow;
	logic [5:0] opCode;
	logic [5:0] funct;
	logic pcWrite, pcWriteCond, iOrD, memWrite, memRead, irWrite, memToReg;
	logic regWrite, extOp, luiOp, pcOrData, err, erWrite;
	logic [1:0] regDst, aluSrcA, aluSrcB, pcSource;
	logic [3:0] aluOp;
	int tbState;   // expected FSM state
	int curKind;
	int errors;
	int failedTests;
	int seed;

	wire [24:0] allOut = {pcWrite, pcWriteCond, iOrD, memWrite, memRead, irWrite, memToReg,
		regWrite, extOp, luiOp, pcOrData, err, erWrite, regDst, aluSrcA, aluSrcB, pcSource, aluOp};
	wire [1:0] rwDst = (curKind == kImm) ? ctrlPkg::dstRt : ctrlPkg::dstRd;

	mcController dut (.*);

	always #50 clk = ~clk;

	always @(posedge clk or posedge reset)
	begin
		if (reset)
			tbState <= sF;
		else
			case (tbState)
				sF: tbState <= sD;
				sD: tbState <= sE;
				sE: tbState <= (curKind == kR || curKind == kShift || curKind == kImm) ? sRW :
					(curKind == kLw) ? sMR : (curKind == kSw) ? sMW :
					(curKind == kJr || curKind == kJalr) ? sRJ : sF;
				sMR: tbState <= sLW;
				sRW: tbState <= overflow ? sOE : sF;
				default: tbState <= sF;
			endcase
	end

	task automatic valueMismatch(input string sig, input int expV, input int gotV);
		$display("error %0t %s expected %0h got %0h", $time, sig, expV, gotV);
		errors++;
	endtask

	task automatic ruleBroken(input string what);
		$display("%0t: %s", $time, what);
		errors++;
	endtask

	function automatic logic [3:0] aluCodeFor(input logic [5:0] op);
		logic [2:0] part;
		case (op)
			ctrlPkg::opRType: part = ctrlPkg::aluOpRType;
			ctrlPkg::opBeq: part = ctrlPkg::aluOpSub;
			ctrlPkg::opAndi: part = ctrlPkg::aluOpAnd;
			ctrlPkg::opSlti, ctrlPkg::opSltiu: part = ctrlPkg::aluOpSlt;
			ctrlPkg::opAddiu: part = ctrlPkg::aluOpAddu;
			default: part = ctrlPkg::aluOpAdd;
		endcase
		return {op[0], part};   // unsigned flag on top
	endfunction

	// cycles from fetch to next fetch
	function automatic int lengthOf(input int kind, input logic ovf);
		case (kind)
			kBeq, kJ, kJal, kBad: return 3;
			kLw: return 5;
			kSw, kJr, kJalr: return 4;
			default: return ovf ? 5 : 4;
		endcase
	endfunction

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	assert property (@(posedge clk) reset |-> allOut == '0)
		else valueMismatch("outputs", 0, int'($sampled(allOut)));
	assert property (@(posedge clk) disable iff (reset) tbState == sF |->
		memRead && irWrite && pcWrite && aluSrcB == ctrlPkg::srcBFour && aluOp[2:0] == 3'b000)
		else ruleBroken("fetch cycle lacks memRead, irWrite, pcWrite or the pc + 4 selects");
	assert property (@(posedge clk) disable iff (reset) tbState == sE |-> aluOp == aluCodeFor(opCode))
		else valueMismatch("aluOp", int'(aluCodeFor($sampled(opCode))), int'($sampled(aluOp)));
	assert property (@(posedge clk) disable iff (reset) tbState == sE |->
		extOp == (opCode != ctrlPkg::opAndi) && luiOp == (opCode == ctrlPkg::opLui))
		else ruleBroken("extOp or luiOp does not match the opcode");
	assert property (@(posedge clk) disable iff (reset)
		tbState == sE && curKind == kShift |-> aluSrcA == ctrlPkg::srcAShamt)
		else valueMismatch("aluSrcA", int'(ctrlPkg::srcAShamt), int'($sampled(aluSrcA)));
	assert property (@(posedge clk) disable iff (reset)
		tbState == sE && (curKind == kImm || curKind == kLw || curKind == kSw) |->
		aluSrcA == ctrlPkg::srcAReg && aluSrcB == ctrlPkg::srcBImm)
		else ruleBroken("immediate operands not selected in execute");
	assert property (@(posedge clk) disable iff (reset) tbState == sRW |-> regWrite && regDst == rwDst)
		else ruleBroken("register write-back missing or with the wrong destination");
	assert property (@(posedge clk) disable iff (reset) regWrite |-> tbState == sRW ||
		tbState == sLW || (tbState == sE && curKind == kJal) || (tbState == sRJ && curKind == kJalr))
		else ruleBroken("regWrite outside a write-back cycle");
	assert property (@(posedge clk) disable iff (reset) tbState == sMR |-> memRead && iOrD)
		else ruleBroken("load memory read without memRead and iOrD");
	assert property (@(posedge clk) disable iff (reset)
		tbState == sLW |-> regWrite && memToReg && regDst == ctrlPkg::dstRt)
		else ruleBroken("load write-back without memToReg into rt");
	assert property (@(posedge clk) disable iff (reset)
		(tbState == sMW) == (memWrite && iOrD && !regWrite))
		else ruleBroken("memWrite not matching the store cycle");
	assert property (@(posedge clk) disable iff (reset)
		(tbState == sOE) == (err && erWrite && pcWrite))
		else ruleBroken("overflow error cycle wrong or missing");
	assert property (@(posedge clk) disable iff (reset) (tbState == sE && curKind == kBeq) ==
		(pcWriteCond && pcSource == ctrlPkg::pcAluOutReg))
		else ruleBroken("branch does not show pcWriteCond with the ALU out source");
	assert property (@(posedge clk) disable iff (reset) tbState == sE && (curKind == kJ ||
		curKind == kJal) |-> pcWrite && pcSource == ctrlPkg::pcJumpTarget)
		else ruleBroken("jump does not write the pc from the jump target");
	assert property (@(posedge clk) disable iff (reset) (tbState == sE && curKind == kJal) ||
		(tbState == sRJ && curKind == kJalr) |-> regWrite && pcOrData &&
		regDst == ((curKind == kJal) ? ctrlPkg::dstRa : ctrlPkg::dstRd))
		else ruleBroken("link write missing or to the wrong register");
	assert property (@(posedge clk) disable iff (reset)
		tbState == sRJ |-> pcWrite && pcSource == ctrlPkg::pcAluOutReg)
		else ruleBroken("register jump does not write the pc from the register");
	assert property (@(posedge clk) disable iff (reset) curKind == kBad && tbState != sF |->
		!(pcWrite || pcWriteCond || memWrite || regWrite || irWrite || erWrite))
		else ruleBroken("undefined opcode raised a write enable");

	task automatic runInstr(input int idx);
		int cycles;
		int errBefore;
		logic [31:0] rnd;
		logic ovfAtRw;
		errBefore = errors;
		ovfAtRw = 1'b0;
		@(posedge clk);
		#1;
		opCode = tblOp[idx];
		funct = tblFn[idx];
		curKind = tblKind[idx];
		cycles = 1;
		while (!irWrite)
		begin
			rnd = $random(seed);
			overflow = rnd[0];   // random in every state
			if (tbState == sRW)
				ovfAtRw = overflow;
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > 8)
			begin
				$display("timeout: no fetch after %s", tblName[idx]);
				$display("TEST FAIL");
				$finish;
			end
		end
		assert (cycles == lengthOf(tblKind[idx], ovfAtRw))
			else valueMismatch("cycles", lengthOf(tblKind[idx], ovfAtRw), cycles);
		if (errors == errBefore)
			$display("%s overflow %0d: ok", tblName[idx], ovfAtRw);
		else
		begin
			$display("%s overflow %0d: failed", tblName[idx], ovfAtRw);
			failedTests++;
		end
	endtask

	initial
	begin
		logic [31:0] rnd;
		int n;
		seed = 64;
		errors = 0;
		failedTests = 0;
		clk = 1'b0;
		reset = 1'b1;
		overflow = 1'b0;
		opCode = '0;
		funct = '0;
		curKind = kR;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		for (n = 0; n < nEntry; n++)
			runInstr(n);
		for (n = 0; n < 40; n++)
		begin
			rnd = $random(seed);
			runInstr(rnd % nEntry);
		end
		@(posedge clk);   // let the last fetch be checked
		#1;
		$display("tests %0d, failed %0d, errors %0d", nEntry + 40, failedTests, errors);
		if (errors == 0 && failedTests == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- filelist.f
src/ctrlPkg.sv
src/decodeIf.sv
src/instrDecoder.sv
src/stateSequencer.sv
src/controlWordGen.sv
src/mcController.sv
dv/controllerTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module controllerTb \
	-f filelist.f \
	-o controllerSim

simOut=$(./obj_dir/controllerSim)
echo "$simOut"

if grep -qx "TEST PASS" <<< "$simOut"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
